/* otp_scrmbl.f */
+incdir+.
scrmbl_pkg.sv
present_enc_round.sv
present_dec_round.sv
scrmbl_key_lut.sv
scrmbl_fsm.sv
otp_scrmbl.sv
scrmbl_checker.sv
scrmbl_assertions.sv
tb_otp_scrmbl.sv

/* otp_scrmbl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scrmbl_defines.svh"

// iterative PRESENT-128 scrambling datapath
// a command is taken in one cycle, the rounds run one per clock, the result shows for one cycle
module otp_scrmbl (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire scrmbl_pkg::scrmbl_req_t req_i,
  input  wire                          valid_i,
  output logic                         ready_o,
  output logic [`SCRMBL_BLOCK_W-1:0]   data_o,
  output logic                         valid_o,
  input  wire                          escalate_i,
  output logic                         fsm_err_o
);

  // start indices, encryption counts up from 1 and decryption down from the last round
  localparam logic [`SCRMBL_IDX_W-1:0] first_idx = 1;
  localparam logic [`SCRMBL_IDX_W-1:0] last_idx  = `SCRMBL_NUM_ROUNDS;

  scrmbl_pkg::scrmbl_ctrl_t   ctrl;
  logic [`SCRMBL_KEY_W-1:0]   enc_key, dec_key;
  logic [`SCRMBL_BLOCK_W-1:0] data_d, data_q, enc_data, dec_data;
  logic [`SCRMBL_KEY_W-1:0]   key_d, key_q, enc_key_nxt, dec_key_nxt;
  logic [`SCRMBL_IDX_W-1:0]   idx_d, idx_q, enc_idx, dec_idx;

  ////////////////////////////////////////
  // control and key tables
  ////////////////////////////////////////

  scrmbl_fsm i_fsm (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .valid_i    (valid_i),
    .cmd_i      (req_i.cmd),
    .escalate_i (escalate_i),
    .ready_o    (ready_o),
    .ctrl_o     (ctrl),
    .valid_o    (valid_o),
    .fsm_err_o  (fsm_err_o)
  );

  // keyed by the select of the command on the request port, only read when it is loaded
  scrmbl_key_lut i_key_lut (
    .sel_i     (req_i.sel),
    .enc_key_o (enc_key),
    .dec_key_o (dec_key)
  );

  ////////////////////////////////////////
  // round logic
  ////////////////////////////////////////

  // both directions see the same working registers, the FSM picks one result
  present_enc_round i_enc_round (
    .data_i (data_q),
    .key_i  (key_q),
    .idx_i  (idx_q),
    .data_o (enc_data),
    .key_o  (enc_key_nxt),
    .idx_o  (enc_idx)
  );

  present_dec_round i_dec_round (
    .data_i (data_q),
    .key_i  (key_q),
    .idx_i  (idx_q),
    .data_o (dec_data),
    .key_o  (dec_key_nxt),
    .idx_o  (dec_idx)
  );

  ////////////////////////////////////////
  // working registers
  ////////////////////////////////////////

  // a load takes the request block and the start key of the requested direction,
  // otherwise the registers take the output of the selected round
  always_comb begin
    if (ctrl.load) begin
      data_d = req_i.data;
      key_d  = ctrl.cmd_dec ? dec_key : enc_key;
      idx_d  = ctrl.cmd_dec ? last_idx : first_idx;
    end else if (ctrl.dec_sel) begin
      data_d = dec_data;
      key_d  = dec_key_nxt;
      idx_d  = dec_idx;
    end else begin
      data_d = enc_data;
      key_d  = enc_key_nxt;
      idx_d  = enc_idx;
    end
  end

  // the registers hold between commands, so the result stays put after the last round
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q <= '0;
      key_q  <= '0;
      idx_q  <= '0;
    end else if (ctrl.load || ctrl.round_en) begin
      data_q <= data_d;
      key_q  <= key_d;
      idx_q  <= idx_d;
    end
  end

  // intermediate round states never reach the output
  assign data_o = ctrl.out_en ? data_q : '0;

endmodule

`default_nettype wire

/* otp_scrmbl_stim.txt */
// three hex words per line: control, input block, expected result
// control digits from the left: hold valid_i, cmd (0 dec 1 enc 2 nop), sel, input from last result, check (0 none 1 exact 2 differs)
01001 0000000000000000 96db702a2e6900af
00001 96db702a2e6900af 0000000000000000
02000 0000000000000000 0000000000000000
01102 0123456789abcdef 0000000000000000
00111 0000000000000000 0123456789abcdef
01202 fedcba9876543210 0000000000000000
00211 0000000000000000 fedcba9876543210
11302 a5a5a5a55a5a5a5a 0000000000000000
00311 0000000000000000 a5a5a5a55a5a5a5a
00102 deadbeefcafef00d 0000000000000000
01111 0000000000000000 deadbeefcafef00d
11002 ffffffffffffffff 0000000000000000
00011 0000000000000000 ffffffffffffffff
00202 0f1e2d3c4b5a6978 0000000000000000
01211 0000000000000000 0f1e2d3c4b5a6978
00302 1122334455667788 0000000000000000
01311 0000000000000000 1122334455667788
02100 0000000000000000 0000000000000000
fffff 0000000000000000 0000000000000000

/* present_dec_round.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scrmbl_defines.svh"

// one inverse PRESENT round, purely combinational
// the key input starts as the fully stepped key and walks back one step per round
module present_dec_round (
  input  wire  [`SCRMBL_BLOCK_W-1:0] data_i,
  input  wire  [`SCRMBL_KEY_W-1:0]   key_i,
  input  wire  [`SCRMBL_IDX_W-1:0]   idx_i,
  output logic [`SCRMBL_BLOCK_W-1:0] data_o,
  output logic [`SCRMBL_KEY_W-1:0]   key_o,
  output logic [`SCRMBL_IDX_W-1:0]   idx_o
);

  // decryption begins at this index, where the output whitening has to be removed
  localparam logic [`SCRMBL_IDX_W-1:0] last_idx = `SCRMBL_NUM_ROUNDS;

  logic [`SCRMBL_BLOCK_W-1:0] whitened;
  logic [`SCRMBL_BLOCK_W-1:0] unpermuted;
  logic [`SCRMBL_BLOCK_W-1:0] unsubstituted;

  // strip the whitening key on the first decrypt round only
  always_comb begin
    whitened = data_i;
    if (idx_i == last_idx) begin
      whitened = data_i ^ key_i[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];
    end
  end

  // the layers come off in reverse order, permutation first
  assign unpermuted = scrmbl_pkg::present_inv_perm64(whitened);

  always_comb begin
    for (int n = 0; n < `SCRMBL_BLOCK_W / 4; n++) begin
      unsubstituted[n*4 +: 4] = scrmbl_pkg::present_inv_sbox4(unpermuted[n*4 +: 4]);
    end
  end

  // step the schedule back to the key that was used as round key for this index
  assign key_o = scrmbl_pkg::present_key_inv_update(key_i, idx_i);

  // removing that round key leaves the state from before the forward round
  assign data_o = unsubstituted ^ key_o[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];

  // counts down toward index 1, the first forward round
  assign idx_o = idx_i - 1'b1;

endmodule

`default_nettype wire

/* present_enc_round.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scrmbl_defines.svh"

// one forward PRESENT round, purely combinational
// the working registers in the top level hold the state between rounds
module present_enc_round (
  input  wire  [`SCRMBL_BLOCK_W-1:0] data_i,
  input  wire  [`SCRMBL_KEY_W-1:0]   key_i,
  input  wire  [`SCRMBL_IDX_W-1:0]   idx_i,
  output logic [`SCRMBL_BLOCK_W-1:0] data_o,
  output logic [`SCRMBL_KEY_W-1:0]   key_o,
  output logic [`SCRMBL_IDX_W-1:0]   idx_o
);

  // index of the last round, which also applies the output whitening
  localparam logic [`SCRMBL_IDX_W-1:0] last_idx = `SCRMBL_NUM_ROUNDS;

  logic [`SCRMBL_BLOCK_W-1:0] key_mixed;
  logic [`SCRMBL_BLOCK_W-1:0] substituted;
  logic [`SCRMBL_BLOCK_W-1:0] permuted;

  // the round key is the upper half of the key register
  assign key_mixed = data_i ^ key_i[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];

  // substitution layer, the same S-box on all sixteen nibbles
  always_comb begin
    for (int n = 0; n < `SCRMBL_BLOCK_W / 4; n++) begin
      substituted[n*4 +: 4] = scrmbl_pkg::present_sbox4(key_mixed[n*4 +: 4]);
    end
  end

  assign permuted = scrmbl_pkg::present_perm64(substituted);

  // the schedule step uses the index of the round that is running now
  assign key_o = scrmbl_pkg::present_key_update(key_i, idx_i);

  // after the last round the freshly updated key is XORed in as well
  always_comb begin
    data_o = permuted;
    if (idx_i == last_idx) begin
      data_o = permuted ^ key_o[`SCRMBL_KEY_W-1 -: `SCRMBL_BLOCK_W];
    end
  end

  // counts up, wraps past the last round but is never used after it
  assign idx_o = idx_i + 1'b1;

endmodule

`default_nettype wire

/* scrmbl_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scrmbl_defines.svh"

// protocol properties of the scrambler ports
module scrmbl_assertions (
  input wire                          clk_i,
  input wire                          rst_ni,
  input wire scrmbl_pkg::scrmbl_req_t req_i,
  input wire                          req_valid_i,
  input wire                          req_ready_i,
  input wire [`SCRMBL_BLOCK_W-1:0]    rsp_data_i,
  input wire                          rsp_valid_i,
  input wire                          fsm_err_i
);

  // a command that starts the rounds, nops do not count
  logic real_cmd;
  assign real_cmd = req_valid_i && req_ready_i &&
                    (req_i.cmd == scrmbl_pkg::CmdEncrypt || req_i.cmd == scrmbl_pkg::CmdDecrypt);

  valid_single_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |=> !rsp_valid_i) else $error("valid_o high for two cycles in a row");

  data_zero_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rsp_valid_i |-> rsp_data_i == '0) else $error("data_o not zero while valid_o is low");

  busy_after_cmd_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    real_cmd |=> !req_ready_i) else $error("ready_o still high after a command was taken");

  err_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_err_i |=> fsm_err_i) else $error("fsm_err_o fell without a reset");

endmodule

bind otp_scrmbl scrmbl_assertions i_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_i       (req_i),
  .req_valid_i (valid_i),
  .req_ready_i (ready_o),
  .rsp_data_i  (data_o),
  .rsp_valid_i (valid_o),
  .fsm_err_i   (fsm_err_o)
);

`default_nettype wire

/* scrmbl_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scrmbl_defines.svh"

// result checker that follows both handshakes and keeps the expected results in a queue
// everything is sampled on the rising edge and the testbench drives its inputs 1 ns later
module scrmbl_checker (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire scrmbl_pkg::scrmbl_req_t req_i,
  input  wire                          req_valid_i,
  input  wire                          req_ready_i,
  input  wire [`SCRMBL_BLOCK_W-1:0]    rsp_data_i,
  input  wire                          rsp_valid_i,
  input  wire                          escalate_i,
  input  wire                          fsm_err_i,
  input  wire [1:0]                    exp_mode_i,
  input  wire [`SCRMBL_BLOCK_W-1:0]    exp_data_i,
  output int                           err_cnt_o
);

  // the result is sampled this many edges after the accepting edge
  localparam int result_lat = `SCRMBL_NUM_ROUNDS + 1;

  // what a command in flight has to produce
  typedef struct packed {
    logic [1:0]                 mode;
    logic [`SCRMBL_BLOCK_W-1:0] expected;
    logic [`SCRMBL_BLOCK_W-1:0] block_in;
  } pending_t;

  pending_t exp_q[$];
  int       lat;
  logic     busy;
  logic     nop_seen;
  logic     esc_seen;

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    err_cnt_o++;
  endtask

  task automatic report_failure(input string what);
    $display("ERROR t=%0t: %s", $time, what);
    err_cnt_o++;
  endtask

  // each valid_o pulse has to close the oldest command in flight
  task automatic check_result();
    pending_t item;
    if (esc_seen) begin
      report_failure("valid_o pulsed after escalation");
    end else if (!busy || exp_q.size() == 0) begin
      report_failure("valid_o pulsed with no command in flight");
    end else begin
      item = exp_q.pop_front();
      busy = 1'b0;
      if (lat != result_lat) begin
        report_failure($sformatf("valid_o came %0d cycles after acceptance, not %0d",
                                 lat, result_lat));
      end
      // mode 1 compares with the file and mode 2 only asks for a changed block
      if (item.mode == 2'd1 && rsp_data_i !== item.expected) begin
        report_mismatch("data_o", rsp_data_i, item.expected);
      end else if (item.mode == 2'd2 && rsp_data_i === item.block_in) begin
        report_failure("data_o equals the block that went in");
      end
    end
  endtask

  ////////////////////////////////////////
  // sampling
  ////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_q.delete();
      lat       = 0;
      busy      = 1'b0;
      nop_seen  = 1'b0;
      esc_seen  = 1'b0;
      err_cnt_o = 0;
    end else begin
      // the error flag stays low until an escalation arrives
      if (!esc_seen && fsm_err_i) report_failure("fsm_err_o is high without an escalation");
      // once escalated the engine stays locked until reset
      if (esc_seen && !fsm_err_i) report_failure("fsm_err_o dropped after escalation");
      if (esc_seen && req_ready_i) report_failure("ready_o is high after escalation");
      if (nop_seen && !esc_seen && !req_ready_i) report_failure("ready_o dropped after a nop");
      nop_seen = 1'b0;

      if (busy) begin
        lat++;
        if (lat <= `SCRMBL_NUM_ROUNDS && req_ready_i) begin
          report_failure("ready_o is high while the rounds run");
        end
      end

      if (rsp_valid_i) begin
        check_result();
      end else if (rsp_data_i !== '0) begin
        report_mismatch("data_o", rsp_data_i, '0);
      end

      if (busy && lat > result_lat) begin
        report_failure("no valid_o followed an accepted command");
        void'(exp_q.pop_front());
        busy = 1'b0;
      end

      // a real command opens a new entry while a nop only has to keep ready_o up
      if (req_valid_i && req_ready_i) begin
        if (req_i.cmd == scrmbl_pkg::CmdEncrypt || req_i.cmd == scrmbl_pkg::CmdDecrypt) begin
          if (busy) report_failure("a command was accepted while another was in flight");
          exp_q.push_back('{mode: exp_mode_i, expected: exp_data_i, block_in: req_i.data});
          busy = 1'b1;
          lat  = 0;
        end else begin
          nop_seen = 1'b1;
        end
      end

      // the command in flight is abandoned by the escalation
      if (escalate_i) begin
        esc_seen = 1'b1;
        busy     = 1'b0;
        exp_q.delete();
      end
    end
  end

endmodule

`default_nettype wire

/* scrmbl_defines.svh */
`ifndef SCRMBL_DEFINES_SVH
`define SCRMBL_DEFINES_SVH

// block and key sizes of the PRESENT-128 variant used by the scrambler
`define SCRMBL_BLOCK_W 64
`define SCRMBL_KEY_W 128

// number of cipher rounds and the width of the round index that walks through them
`define SCRMBL_NUM_ROUNDS 31
`define SCRMBL_IDX_W 5

// fixed key slots, one of which is picked per command through sel
`define SCRMBL_NUM_KEYS 4
`define SCRMBL_SEL_W 2

// key 0 is all zeros so the published zero-key PRESENT-128 vector can be used as a check
`define SCRMBL_KEY0 128'h0000_0000_0000_0000_0000_0000_0000_0000
// the other slots hold arbitrary fixed netlist constants
`define SCRMBL_KEY1 128'h3ba1_02e8_1f0c_7d54_96e2_a3b1_c4d8_5f07
`define SCRMBL_KEY2 128'hd2f4_6c19_8a3e_07b5_5e71_c0a9_24bd_f863
`define SCRMBL_KEY3 128'h7c05_e9a2_b418_3fd6_0a9f_6e27_d153_8b4c

`endif

/* scrmbl_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scrmbl_defines.svh"

// control FSM of the scrambling engine
// it accepts one command in IdleSt, runs the rounds and flags the result for one cycle
module scrmbl_fsm (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          valid_i,
  input  wire scrmbl_pkg::scrmbl_cmd_e cmd_i,
  input  wire                          escalate_i,
  output logic                         ready_o,
  output scrmbl_pkg::scrmbl_ctrl_t     ctrl_o,
  output logic                         valid_o,
  output logic                         fsm_err_o
);

  // counter value in the cycle of the final round
  localparam logic [`SCRMBL_IDX_W-1:0] last_cnt = `SCRMBL_NUM_ROUNDS - 1;

  scrmbl_pkg::scrmbl_state_e state_d, state_q;
  logic [`SCRMBL_IDX_W-1:0]  cnt_d, cnt_q;
  logic                      valid_d, valid_q;

  ////////////////////////////////////////
  // next state and control decode
  ////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q;
    valid_d   = 1'b0;
    ready_o   = 1'b0;
    fsm_err_o = 1'b0;
    ctrl_o    = '0;

    case (state_q)
      // wait for a command, the working registers load on the accepting edge
      scrmbl_pkg::IdleSt: begin
        ready_o = 1'b1;
        cnt_d   = '0;
        if (valid_i) begin
          case (cmd_i)
            scrmbl_pkg::CmdEncrypt: begin
              state_d     = scrmbl_pkg::EncryptSt;
              ctrl_o.load = 1'b1;
            end
            scrmbl_pkg::CmdDecrypt: begin
              state_d        = scrmbl_pkg::DecryptSt;
              ctrl_o.load    = 1'b1;
              ctrl_o.cmd_dec = 1'b1;
            end
            // nop and unused codes are taken and leave everything as it was
            default: ;
          endcase
        end
      end

      // one round per cycle, the counter tells when the last one runs
      scrmbl_pkg::EncryptSt, scrmbl_pkg::DecryptSt: begin
        ctrl_o.round_en = 1'b1;
        ctrl_o.dec_sel  = (state_q == scrmbl_pkg::DecryptSt);
        cnt_d           = cnt_q + 1'b1;
        if (cnt_q == last_cnt) begin
          state_d = scrmbl_pkg::IdleSt;
          valid_d = 1'b1;
        end
      end

      // terminal, only reset leaves this state
      scrmbl_pkg::ErrorSt: begin
        fsm_err_o = 1'b1;
      end

      // An encoding outside the legal set means the state register was disturbed.
      default: begin
        state_d   = scrmbl_pkg::ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // escalation wins over everything and freezes the datapath
    if (escalate_i) begin
      state_d         = scrmbl_pkg::ErrorSt;
      valid_d         = 1'b0;
      ready_o         = 1'b0;
      ctrl_o.load     = 1'b0;
      ctrl_o.round_en = 1'b0;
    end

    // the top level shows the data register only while the result is flagged
    ctrl_o.out_en = valid_q;
  end

  assign valid_o = valid_q;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= scrmbl_pkg::IdleSt;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      valid_q <= valid_d;
    end
  end

endmodule

`default_nettype wire

/* scrmbl_key_lut.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scrmbl_defines.svh"

// fixed key tables for both cipher directions
// both outputs follow sel_i with no register in between
module scrmbl_key_lut (
  input  wire  [`SCRMBL_SEL_W-1:0] sel_i,
  output logic [`SCRMBL_KEY_W-1:0] enc_key_o,
  output logic [`SCRMBL_KEY_W-1:0] dec_key_o
);

  // encryption keys straight from the netlist constants
  localparam logic [`SCRMBL_KEY_W-1:0] enc_key_tbl [`SCRMBL_NUM_KEYS] = '{
    `SCRMBL_KEY0,
    `SCRMBL_KEY1,
    `SCRMBL_KEY2,
    `SCRMBL_KEY3
  };

  logic [`SCRMBL_KEY_W-1:0] enc_lut [`SCRMBL_NUM_KEYS];
  logic [`SCRMBL_KEY_W-1:0] dec_lut [`SCRMBL_NUM_KEYS];

  ////////////////////////////////////////
  // table build
  ////////////////////////////////////////

  // the decrypt keys are folded to constants while the design elaborates,
  // so no schedule logic is left in the netlist for them
  for (genvar i = 0; i < `SCRMBL_NUM_KEYS; i++) begin : gen_keys
    localparam logic [`SCRMBL_KEY_W-1:0] dec_key = scrmbl_pkg::present_dec_key(enc_key_tbl[i]);

    assign enc_lut[i] = enc_key_tbl[i];
    assign dec_lut[i] = dec_key;
  end

  ////////////////////////////////////////
  // selection
  ////////////////////////////////////////

  // four slots and a 2-bit select, so every select value hits a defined entry
  assign enc_key_o = enc_lut[sel_i];
  assign dec_key_o = dec_lut[sel_i];

endmodule

`default_nettype wire

/* scrmbl_pkg.sv */
`default_nettype none

`include "scrmbl_defines.svh"

package scrmbl_pkg;

  // command opcodes, any code other than encrypt or decrypt is accepted and dropped
  typedef enum logic [1:0] {
    CmdDecrypt = 2'd0,
    CmdEncrypt = 2'd1,
    CmdNop     = 2'd2
  } scrmbl_cmd_e;

  // sparse state encoding, every pair of legal states differs in at least five bits
  typedef enum logic [8:0] {
    IdleSt    = 9'b100011001,
    DecryptSt = 9'b101101111,
    EncryptSt = 9'b010010111,
    ErrorSt   = 9'b011111000
  } scrmbl_state_e;

  // one command as it arrives on the request side
  typedef struct packed {
    scrmbl_cmd_e                cmd;
    logic [`SCRMBL_SEL_W-1:0]   sel;
    logic [`SCRMBL_BLOCK_W-1:0] data;
  } scrmbl_req_t;

  // datapath steering from the FSM
  typedef struct packed {
    logic load;      // take the initial data, key and index
    logic dec_sel;   // use the decrypt round instead of the encrypt round
    logic round_en;  // advance the working registers by one round
    logic cmd_dec;   // the load belongs to a decrypt command
    logic out_en;    // a result is being presented this cycle
  } scrmbl_ctrl_t;

  // forward and inverse 4-bit S-boxes, table entry n sits at nibble n
  function automatic logic [3:0] present_sbox4(input logic [3:0] nib);
    logic [15:0][3:0] tbl;
    tbl = 64'h21748fe3da09b65c;
    return tbl[nib];
  endfunction

  function automatic logic [3:0] present_inv_sbox4(input logic [3:0] nib);
    logic [15:0][3:0] tbl;
    tbl = 64'ha970364bd21c8fe5;
    return tbl[nib];
  endfunction

  // bit k moves to position 16*k mod 63, bit 63 stays in place
  function automatic logic [`SCRMBL_BLOCK_W-1:0] present_perm64(
    input logic [`SCRMBL_BLOCK_W-1:0] din
  );
    logic [`SCRMBL_BLOCK_W-1:0] dout;
    for (int k = 0; k < 63; k++) begin
      dout[(k * 16) % 63] = din[k];
    end
    dout[63] = din[63];
    return dout;
  endfunction

  function automatic logic [`SCRMBL_BLOCK_W-1:0] present_inv_perm64(
    input logic [`SCRMBL_BLOCK_W-1:0] din
  );
    logic [`SCRMBL_BLOCK_W-1:0] dout;
    for (int k = 0; k < 63; k++) begin
      dout[k] = din[(k * 16) % 63];
    end
    dout[63] = din[63];
    return dout;
  endfunction

  // key schedule step: rotate left by 61, S-box the two top nibbles, mix in the round index
  function automatic logic [`SCRMBL_KEY_W-1:0] present_key_update(
    input logic [`SCRMBL_KEY_W-1:0] key_in,
    input logic [`SCRMBL_IDX_W-1:0] idx
  );
    logic [`SCRMBL_KEY_W-1:0] key_out;
    key_out            = {key_in[66:0], key_in[127:67]};
    key_out[127:124]   = present_sbox4(key_out[127:124]);
    key_out[123:120]   = present_sbox4(key_out[123:120]);
    key_out[66:62]     = key_out[66:62] ^ idx;
    return key_out;
  endfunction

  // undoes present_key_update for the same index, the steps run in reverse order
  function automatic logic [`SCRMBL_KEY_W-1:0] present_key_inv_update(
    input logic [`SCRMBL_KEY_W-1:0] key_in,
    input logic [`SCRMBL_IDX_W-1:0] idx
  );
    logic [`SCRMBL_KEY_W-1:0] key_tmp;
    key_tmp            = key_in;
    key_tmp[66:62]     = key_tmp[66:62] ^ idx;
    key_tmp[127:124]   = present_inv_sbox4(key_tmp[127:124]);
    key_tmp[123:120]   = present_inv_sbox4(key_tmp[123:120]);
    return {key_tmp[60:0], key_tmp[127:61]};
  endfunction

  // the decrypt start key is the key after all forward schedule steps
  function automatic logic [`SCRMBL_KEY_W-1:0] present_dec_key(
    input logic [`SCRMBL_KEY_W-1:0] key_in
  );
    logic [`SCRMBL_KEY_W-1:0] key_tmp;
    key_tmp = key_in;
    for (int i = 1; i <= `SCRMBL_NUM_ROUNDS; i++) begin
      key_tmp = present_key_update(key_tmp, i[`SCRMBL_IDX_W-1:0]);
    end
    return key_tmp;
  endfunction

endpackage

`default_nettype wire

/* tb_otp_scrmbl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "scrmbl_defines.svh"

// testbench top that plays the stimulus file and then locks the engine with an escalation
module tb_otp_scrmbl;

  localparam int max_entries    = 32;
  localparam int ready_timeout  = 80;
  localparam int result_timeout = 80;
  localparam int lock_cycles    = 60;
  localparam logic [63:0] end_marker = 64'hfffff;

  logic                       clk_i;
  logic                       rst_ni;
  scrmbl_pkg::scrmbl_req_t    req_i;
  logic                       valid_i;
  logic                       ready_o;
  logic [`SCRMBL_BLOCK_W-1:0] data_o;
  logic                       valid_o;
  logic                       escalate_i;
  logic                       fsm_err_o;
  logic [1:0]                 exp_mode;
  logic [`SCRMBL_BLOCK_W-1:0] exp_data;
  logic [`SCRMBL_BLOCK_W-1:0] last_result;
  logic [63:0]                stim_mem [0:3*max_entries-1];
  logic [31:0]                lcg_state;
  int                         chk_errs;
  int                         tb_errs;
  logic                       aborted;

  always #2 clk_i = ~clk_i;

  otp_scrmbl i_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .valid_i    (valid_i),
    .ready_o    (ready_o),
    .data_o     (data_o),
    .valid_o    (valid_o),
    .escalate_i (escalate_i),
    .fsm_err_o  (fsm_err_o)
  );

  scrmbl_checker i_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (valid_i),
    .req_ready_i (ready_o),
    .rsp_data_i  (data_o),
    .rsp_valid_i (valid_o),
    .escalate_i  (escalate_i),
    .fsm_err_i   (fsm_err_o),
    .exp_mode_i  (exp_mode),
    .exp_data_i  (exp_data),
    .err_cnt_o   (chk_errs)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic report_timeout(input string what);
    $display("ERROR t=%0t: timed out waiting for %s", $time, what);
    tb_errs++;
    aborted = 1'b1;
  endtask

  // raises valid_i, waits for ready_o and returns 1 ns after the accepting edge
  task automatic send_cmd(input logic hold);
    int waited;
    valid_i = 1'b1;
    waited  = 0;
    while (!ready_o && waited < ready_timeout) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (!ready_o) begin
      valid_i = 1'b0;
      report_timeout("ready_o");
    end else begin
      @(posedge clk_i);
      #1;
      if (!hold) valid_i = 1'b0;
    end
  endtask

  // a held valid_i is dropped as soon as ready_o comes back with the result
  task automatic wait_result();
    int waited;
    waited = 0;
    while (!valid_o && waited < result_timeout) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    valid_i = 1'b0;
    if (!valid_o) report_timeout("valid_o");
    else last_result = data_o;
  endtask

  initial begin
    int          idx;
    int          gap;
    int          waited;
    logic [63:0] ctrl;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_i       = '0;
    valid_i     = 1'b0;
    escalate_i  = 1'b0;
    exp_mode    = '0;
    exp_data    = '0;
    last_result = '0;
    lcg_state   = 32'd6;
    tb_errs     = 0;
    aborted     = 1'b0;
    $readmemh("otp_scrmbl_stim.txt", stim_mem);

    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    ////////////////////////////////////////
    // commands from the stimulus file
    ////////////////////////////////////////
    idx = 0;
    while (!aborted && idx < max_entries && stim_mem[3*idx] !== end_marker) begin
      ctrl = stim_mem[3*idx];
      if ($isunknown(ctrl)) begin
        $display("ERROR t=%0t: stimulus file has no end marker", $time);
        tb_errs++;
        aborted = 1'b1;
      end else begin
        req_i.cmd  = scrmbl_pkg::scrmbl_cmd_e'(ctrl[13:12]);
        req_i.sel  = ctrl[9:8];
        req_i.data = ctrl[4] ? last_result : stim_mem[3*idx+1];
        exp_mode   = ctrl[1:0];
        exp_data   = stim_mem[3*idx+2];
        send_cmd(ctrl[16]);
        if (!aborted && ctrl[1:0] != 2'd0) wait_result();
        // idle gap of 0 to 3 cycles between commands
        lcg_state = lcg_step(lcg_state);
        gap = lcg_state[17:16];
        repeat (gap) begin
          @(posedge clk_i);
          #1;
        end
      end
      idx++;
    end

    ////////////////////////////////////////
    // escalation phase
    ////////////////////////////////////////
    if (!aborted) begin
      @(posedge clk_i);
      #1;
      // start an encryption and cut it off in the middle of its rounds
      req_i    = '{cmd: scrmbl_pkg::CmdEncrypt, sel: 2'd1, data: '0};
      exp_mode = 2'd2;
      send_cmd(1'b0);
      repeat (5) begin
        @(posedge clk_i);
        #1;
      end
      escalate_i = 1'b1;
      @(posedge clk_i);
      #1;
      escalate_i = 1'b0;
      // keep requesting since the locked engine must never answer
      valid_i = 1'b1;
      waited  = 0;
      while (!valid_o && !ready_o && waited < lock_cycles) begin
        @(posedge clk_i);
        #1;
        waited++;
      end
      valid_i = 1'b0;
      if (valid_o || ready_o) begin
        $display("ERROR t=%0t: the engine answered after escalation", $time);
        tb_errs++;
      end
      if (!fsm_err_o) begin
        $display("ERROR t=%0t: fsm_err_o is low after escalation", $time);
        tb_errs++;
      end
    end

    repeat (2) @(posedge clk_i);
    #1;
    $display("errors: %0d in the checker, %0d in the testbench", chk_errs, tb_errs);
    if (chk_errs == 0 && tb_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
